/* axi_pkg.sv */
//----------------------------
// PCIe slave AXI port constants
// Single-beat accesses only, so no burst or strobe fields
// A 512-bit beat is sixteen 32-bit lanes picked by addr[5:2]
//----------------------------
`default_nettype none

package axi_pkg;

   // Port widths
   localparam int AXI_ID_W   = 5;
   localparam int AXI_ADDR_W = 64;
   localparam int AXI_DATA_W = 512;

   // Lane split of the data beat
   localparam int LANE_W       = 32;
   localparam int NUM_LANES    = 16;
   localparam int LANE_SEL_LSB = 2;
   localparam int LANE_SEL_MSB = 5;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // One beat, seen flat or as lanes
   typedef union packed {
      logic [AXI_DATA_W-1:0]            flat;
      logic [NUM_LANES-1:0][LANE_W-1:0] lane;
   } axi_beat_u;

endpackage

`default_nettype wire

/* cfg_bus_if.sv */
//----------------------------
// Simple config bus
// wr/rd are one-cycle pulses, one ack per pulse
// rdata is valid only in the ack cycle
//----------------------------
`default_nettype none

interface cfg_bus_if
   import regmap_pkg::*;
();

   logic [CFG_ADDR_W-1:0] addr;
   logic [CFG_DATA_W-1:0] wdata;
   logic                  wr;
   logic                  rd;
   logic                  ack;
   logic [CFG_DATA_W-1:0] rdata;

   modport master (
      output addr, wdata, wr, rd,
      input  ack, rdata
   );

   modport target (
      input  addr, wdata, wr, rd,
      output ack, rdata
   );

endinterface

`default_nettype wire

/* cl_hello_world.sv */
//----------------------------
// Hello world custom logic, PCIe slave port 0 only
// Request channels pass a one-entry slice
// Response channels come straight from the bridge
//----------------------------
`default_nettype none

module cl_hello_world
   import axi_pkg::*;
(
   input  logic                  clk,
   input  logic                  sync_rst_n,
   input  logic [AXI_ID_W-1:0]   sh_cl_pcis_awid,
   input  logic [AXI_ADDR_W-1:0] sh_cl_pcis_awaddr,
   input  logic                  sh_cl_pcis_awvalid,
   output logic                  cl_sh_pcis_awready,
   input  axi_beat_u             sh_cl_pcis_wdata,
   input  logic                  sh_cl_pcis_wvalid,
   output logic                  cl_sh_pcis_wready,
   output logic [AXI_ID_W-1:0]   cl_sh_pcis_bid,
   output logic [1:0]            cl_sh_pcis_bresp,
   output logic                  cl_sh_pcis_bvalid,
   input  logic                  sh_cl_pcis_bready,
   input  logic [AXI_ID_W-1:0]   sh_cl_pcis_arid,
   input  logic [AXI_ADDR_W-1:0] sh_cl_pcis_araddr,
   input  logic                  sh_cl_pcis_arvalid,
   output logic                  cl_sh_pcis_arready,
   output logic [AXI_ID_W-1:0]   cl_sh_pcis_rid,
   output axi_beat_u             cl_sh_pcis_rdata,
   output logic [1:0]            cl_sh_pcis_rresp,
   output logic                  cl_sh_pcis_rlast,
   output logic                  cl_sh_pcis_rvalid,
   input  logic                  sh_cl_pcis_rready
);

   pcis_req_if req_if ();
   cfg_bus_if  cfg_if ();

   pcis_req_slice u_req_slice (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .awid       (sh_cl_pcis_awid),
      .awaddr     (sh_cl_pcis_awaddr),
      .awvalid    (sh_cl_pcis_awvalid),
      .awready    (cl_sh_pcis_awready),
      .wdata      (sh_cl_pcis_wdata),
      .wvalid     (sh_cl_pcis_wvalid),
      .wready     (cl_sh_pcis_wready),
      .arid       (sh_cl_pcis_arid),
      .araddr     (sh_cl_pcis_araddr),
      .arvalid    (sh_cl_pcis_arvalid),
      .arready    (cl_sh_pcis_arready),
      .req        (req_if.slice_side)
   );

   pcis_slave_bridge u_bridge (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .req        (req_if.bridge_side),
      .cfg        (cfg_if.master),
      .bid        (cl_sh_pcis_bid),
      .bresp      (cl_sh_pcis_bresp),
      .bvalid     (cl_sh_pcis_bvalid),
      .bready     (sh_cl_pcis_bready),
      .rid        (cl_sh_pcis_rid),
      .rdata      (cl_sh_pcis_rdata),
      .rresp      (cl_sh_pcis_rresp),
      .rlast      (cl_sh_pcis_rlast),
      .rvalid     (cl_sh_pcis_rvalid),
      .rready     (sh_cl_pcis_rready)
   );

   hello_world_reg u_hello_world (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .cfg        (cfg_if.target)
   );

endmodule

`default_nettype wire

/* hello_world_reg.sv */
//----------------------------
// Hello world register target
// ack follows each pulse by exactly 2 cycles
// Reads of offset 0x00 return the value byte-reversed
//----------------------------
`default_nettype none

module hello_world_reg
   import regmap_pkg::*;
(
   input  logic      clk,
   input  logic      sync_rst_n,
   cfg_bus_if.target cfg
);

   logic                  wr_stretch;
   logic                  rd_stretch;
   logic                  ack_q;
   logic [CFG_ADDR_W-1:0] addr_q;
   logic [CFG_DATA_W-1:0] wdata_q;
   logic [CFG_DATA_W-1:0] rdata_q;
   logic [CFG_DATA_W-1:0] hello_world_q;

   // Pulses held until ack
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         wr_stretch <= 1'b0;
         rd_stretch <= 1'b0;
         ack_q      <= 1'b0;
      end
      else
      begin
         wr_stretch <= cfg.wr || (wr_stretch && !ack_q);
         rd_stretch <= cfg.rd || (rd_stretch && !ack_q);
         ack_q      <= (wr_stretch || rd_stretch) && !ack_q;
      end

   always_ff @(posedge clk)
      if (cfg.wr || cfg.rd)
      begin
         addr_q  <= cfg.addr;
         wdata_q <= cfg.wdata;
      end

   //----------------------------
   // Register and readback
   //----------------------------
   // Updated on the edge that raises ack
   always_ff @(posedge clk)
      if (!sync_rst_n)
         hello_world_q <= HELLO_WORLD_RST;
      else if (wr_stretch && !ack_q && (addr_q == HELLO_WORLD_OFS))
         hello_world_q <= wdata_q;

   always_ff @(posedge clk)
      case (addr_q)
         HELLO_WORLD_OFS: rdata_q <= {<<8{hello_world_q}};
         default:         rdata_q <= UNMAPPED_RDATA;
      endcase

   assign cfg.ack   = ack_q;
   assign cfg.rdata = rdata_q;

endmodule

`default_nettype wire

/* pcis_req_if.sv */
//----------------------------
// Sliced AXI request channels
// Payload holds while valid is high and ready is low
//----------------------------
`default_nettype none

interface pcis_req_if
   import axi_pkg::*;
();

   // Write address
   logic [AXI_ID_W-1:0]   awid;
   logic [AXI_ADDR_W-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;

   // Write data
   axi_beat_u             wdata;
   logic                  wvalid;
   logic                  wready;

   // Read address
   logic [AXI_ID_W-1:0]   arid;
   logic [AXI_ADDR_W-1:0] araddr;
   logic                  arvalid;
   logic                  arready;

   modport slice_side (
      output awid, awaddr, awvalid, wdata, wvalid, arid, araddr, arvalid,
      input  awready, wready, arready
   );

   modport bridge_side (
      input  awid, awaddr, awvalid, wdata, wvalid, arid, araddr, arvalid,
      output awready, wready, arready
   );

endinterface

`default_nettype wire

/* pcis_req_slice.sv */
//----------------------------
// One holding entry per request channel
// Accepted input shows at the output one edge later
// Readies are low in reset and in the first cycle after it
//----------------------------
`default_nettype none

module pcis_req_slice
   import axi_pkg::*;
(
   input  logic                  clk,
   input  logic                  sync_rst_n,
   input  logic [AXI_ID_W-1:0]   awid,
   input  logic [AXI_ADDR_W-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  axi_beat_u             wdata,
   input  logic                  wvalid,
   output logic                  wready,
   input  logic [AXI_ID_W-1:0]   arid,
   input  logic [AXI_ADDR_W-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   pcis_req_if.slice_side        req
);

   logic                  rdy_en;
   logic                  aw_full;
   logic [AXI_ID_W-1:0]   aw_id_q;
   logic [AXI_ADDR_W-1:0] aw_addr_q;
   logic                  w_full;
   axi_beat_u             w_data_q;
   logic                  ar_full;
   logic [AXI_ID_W-1:0]   ar_id_q;
   logic [AXI_ADDR_W-1:0] ar_addr_q;

   always_ff @(posedge clk)
      if (!sync_rst_n)
         rdy_en <= 1'b0;
      else
         rdy_en <= 1'b1;

   // Take a new beat when empty or when the bridge pops this cycle
   assign awready = rdy_en && (!aw_full || req.awready);
   assign wready  = rdy_en && (!w_full || req.wready);
   assign arready = rdy_en && (!ar_full || req.arready);

   //----------------------------
   // Entry flags
   //----------------------------
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         aw_full <= 1'b0;
         w_full  <= 1'b0;
         ar_full <= 1'b0;
      end
      else
      begin
         if (awready)
            aw_full <= awvalid;
         if (wready)
            w_full <= wvalid;
         if (arready)
            ar_full <= arvalid;
      end

   // Payloads
   always_ff @(posedge clk)
   begin
      if (awvalid && awready)
      begin
         aw_id_q   <= awid;
         aw_addr_q <= awaddr;
      end
      if (wvalid && wready)
         w_data_q <= wdata;
      if (arvalid && arready)
      begin
         ar_id_q   <= arid;
         ar_addr_q <= araddr;
      end
   end

   assign req.awid    = aw_id_q;
   assign req.awaddr  = aw_addr_q;
   assign req.awvalid = aw_full;
   assign req.wdata   = w_data_q;
   assign req.wvalid  = w_full;
   assign req.arid    = ar_id_q;
   assign req.araddr  = ar_addr_q;
   assign req.arvalid = ar_full;

endmodule

`default_nettype wire

/* pcis_slave_bridge.sv */
//----------------------------
// AXI slave to config bus bridge
// One access in flight, write wins over read
// Every response is OKAY, rlast is always high
// Request entries are popped on the ack cycle
//----------------------------
`default_nettype none

module pcis_slave_bridge
   import axi_pkg::*;
   import regmap_pkg::*;
(
   input  logic                clk,
   input  logic                sync_rst_n,
   pcis_req_if.bridge_side     req,
   cfg_bus_if.master           cfg,
   output logic [AXI_ID_W-1:0] bid,
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   output logic [AXI_ID_W-1:0] rid,
   output axi_beat_u           rdata,
   output logic [1:0]          rresp,
   output logic                rlast,
   output logic                rvalid,
   input  logic                rready
);

   enum logic [1:0] {
      SLV_IDLE,
      SLV_ADDR,
      SLV_CYC,
      SLV_RESP
   } state, state_nxt;

   logic                  wr_req;
   logic                  cyc_wr;
   logic                  cyc_end;
   logic                  rsp_ready;
   logic [AXI_ID_W-1:0]   id_q;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic [CFG_DATA_W-1:0] wdata_q;
   logic [CFG_DATA_W-1:0] rdata_q;
   logic                  wr_q;
   logic                  rd_q;

   // A write needs both address and data waiting
   assign wr_req    = req.awvalid && req.wvalid;
   assign cyc_end   = (state == SLV_CYC) && cfg.ack;
   assign rsp_ready = cyc_wr ? bready : rready;

   //----------------------------
   // State machine
   //----------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         SLV_IDLE:
            if (wr_req || req.arvalid)
               state_nxt = SLV_ADDR;
         SLV_ADDR:
            state_nxt = SLV_CYC;
         SLV_CYC:
            if (cfg.ack)
               state_nxt = SLV_RESP;
         SLV_RESP:
            if (rsp_ready)
               state_nxt = SLV_IDLE;
         default:
            state_nxt = SLV_IDLE;
      endcase
   end

   always_ff @(posedge clk)
      if (!sync_rst_n)
         state <= SLV_IDLE;
      else
         state <= state_nxt;

   // Latch the winner in idle
   always_ff @(posedge clk)
      if (!sync_rst_n)
         cyc_wr <= 1'b0;
      else if (state == SLV_IDLE)
         cyc_wr <= wr_req;

   always_ff @(posedge clk)
      if (state == SLV_IDLE)
      begin
         id_q   <= wr_req ? req.awid : req.arid;
         addr_q <= wr_req ? req.awaddr : req.araddr;
      end

   //----------------------------
   // Config bus cycle
   //----------------------------
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         wr_q <= 1'b0;
         rd_q <= 1'b0;
      end
      else
      begin
         wr_q <= (state == SLV_ADDR) && cyc_wr;
         rd_q <= (state == SLV_ADDR) && !cyc_wr;
      end

   // Lane of the beat picked by addr[5:2]
   always_ff @(posedge clk)
   begin
      if (state == SLV_ADDR)
         wdata_q <= req.wdata.lane[addr_q[LANE_SEL_MSB:LANE_SEL_LSB]];
      if (cyc_end)
         rdata_q <= cfg.rdata;
   end

   assign cfg.addr  = addr_q[CFG_ADDR_W-1:0];
   assign cfg.wdata = wdata_q;
   assign cfg.wr    = wr_q;
   assign cfg.rd    = rd_q;

   // Pop the slice entries once the target has answered
   assign req.awready = cyc_end && cyc_wr;
   assign req.wready  = cyc_end && cyc_wr;
   assign req.arready = cyc_end && !cyc_wr;

   //----------------------------
   // Responses
   //----------------------------
   assign bid    = id_q;
   assign bresp  = RESP_OKAY;
   assign bvalid = (state == SLV_RESP) && cyc_wr;

   assign rid    = id_q;
   assign rresp  = RESP_OKAY;
   assign rlast  = 1'b1;
   assign rvalid = (state == SLV_RESP) && !cyc_wr;

   // Read word back in its own lane, others zero
   always_comb
   begin
      rdata = '0;
      rdata.lane[addr_q[LANE_SEL_MSB:LANE_SEL_LSB]] = rdata_q;
   end

endmodule

`default_nettype wire

/* regmap_pkg.sv */
//----------------------------
// Register map of the config bus
// Only the low 8 address bits are decoded
//----------------------------
`default_nettype none

package regmap_pkg;

   localparam int CFG_ADDR_W = 8;
   localparam int CFG_DATA_W = 32;

   // Hello world register
   localparam logic [CFG_ADDR_W-1:0] HELLO_WORLD_OFS = 8'h00;
   localparam logic [CFG_DATA_W-1:0] HELLO_WORLD_RST = 32'h0000_0000;

   // Returned for every offset without a register
   localparam logic [CFG_DATA_W-1:0] UNMAPPED_RDATA = '1;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/100ps \
   --top-module tb_cl_hello_world -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
exit 1

/* tb.f */
axi_pkg.sv
regmap_pkg.sv
pcis_req_if.sv
cfg_bus_if.sv
pcis_req_slice.sv
pcis_slave_bridge.sv
hello_world_reg.sv
cl_hello_world.sv
tb_clk_gen.sv
tb_cl_hello_world.sv

/* tb_cl_hello_world.sv */
//----------------------------
// Testbench for the hello world custom logic
// Single-beat AXI accesses one at a time
// Only the write/read race presents requests together
// Inputs change 1 ns after a rising edge
// Readies are sampled mid-cycle
// Concurrent assertions do all the checking
//----------------------------
`default_nettype none

module tb_cl_hello_world
   import axi_pkg::*;
   import regmap_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // About 63 accesses of at most 16 cycles each, with twice that margin
   localparam int MAX_CYCLES = 2000;

   logic                  clk;
   logic                  sync_rst_n;
   logic [AXI_ID_W-1:0]   awid;
   logic [AXI_ADDR_W-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   axi_beat_u             wdata;
   logic                  wvalid;
   logic                  wready;
   logic [AXI_ID_W-1:0]   bid;
   logic [1:0]            bresp;
   logic                  bvalid;
   logic                  bready;
   logic [AXI_ID_W-1:0]   arid;
   logic [AXI_ADDR_W-1:0] araddr;
   logic                  arvalid;
   logic                  arready;
   logic [AXI_ID_W-1:0]   rid;
   axi_beat_u             rdata;
   logic [1:0]            rresp;
   logic                  rlast;
   logic                  rvalid;
   logic                  rready;

   // Reference model and expectations
   logic [CFG_DATA_W-1:0] model_reg = '0;
   logic [AXI_ID_W-1:0]   exp_bid = '0;
   logic [AXI_ID_W-1:0]   exp_rid = '0;
   logic [AXI_DATA_W-1:0] exp_rdata = '0;
   logic                  wr_outstanding = 1'b0;
   string                 test_name = "startup";
   int                    cycle_count = 0;

   // Previous-cycle copies for the hold checks
   logic                  in_reset_q = 1'b0;
   logic                  b_stall_q = 1'b0;
   logic                  r_stall_q = 1'b0;
   logic [AXI_ID_W-1:0]   bid_q;
   logic [AXI_ID_W-1:0]   rid_q;
   logic [AXI_DATA_W-1:0] rdata_q;

   tb_clk_gen u_clk_gen (
      .clk        (clk),
      .sync_rst_n (sync_rst_n)
   );

   cl_hello_world dut (
      .clk                (clk),
      .sync_rst_n         (sync_rst_n),
      .sh_cl_pcis_awid    (awid),
      .sh_cl_pcis_awaddr  (awaddr),
      .sh_cl_pcis_awvalid (awvalid),
      .cl_sh_pcis_awready (awready),
      .sh_cl_pcis_wdata   (wdata),
      .sh_cl_pcis_wvalid  (wvalid),
      .cl_sh_pcis_wready  (wready),
      .cl_sh_pcis_bid     (bid),
      .cl_sh_pcis_bresp   (bresp),
      .cl_sh_pcis_bvalid  (bvalid),
      .sh_cl_pcis_bready  (bready),
      .sh_cl_pcis_arid    (arid),
      .sh_cl_pcis_araddr  (araddr),
      .sh_cl_pcis_arvalid (arvalid),
      .cl_sh_pcis_arready (arready),
      .cl_sh_pcis_rid     (rid),
      .cl_sh_pcis_rdata   (rdata),
      .cl_sh_pcis_rresp   (rresp),
      .cl_sh_pcis_rlast   (rlast),
      .cl_sh_pcis_rvalid  (rvalid),
      .sh_cl_pcis_rready  (rready)
   );

   //----------------------------
   // Failure reporting
   //----------------------------
   task automatic report_mismatch(input string what, input logic [AXI_DATA_W-1:0] exp_val,
                                  input logic [AXI_DATA_W-1:0] act_val);
      $display("FAIL %s %s: expected %0h actual %0h", test_name, what, exp_val, act_val);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic report_error(input string what);
      $display("Error in %s: %s", test_name, what);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
         report_error("timeout, the run did not finish within the cycle limit");
   end

   always @(posedge clk)
   begin
      in_reset_q <= !sync_rst_n;
      b_stall_q  <= bvalid && !bready;
      r_stall_q  <= rvalid && !rready;
      bid_q      <= bid;
      rid_q      <= rid;
      rdata_q    <= rdata.flat;
   end

   //----------------------------
   // Checks
   //----------------------------
   a_reset_quiet: assert property (@(posedge clk) (in_reset_q && !sync_rst_n) |->
      !(awready || wready || arready || bvalid || rvalid ||
        dut.cfg_if.wr || dut.cfg_if.rd || dut.cfg_if.ack))
      else report_error("a ready, valid or config bus output was high in reset");

   a_bid: assert property (@(posedge clk) disable iff (!sync_rst_n)
      bvalid |-> bid == exp_bid) else report_mismatch("bid", exp_bid, bid);
   a_bresp: assert property (@(posedge clk) disable iff (!sync_rst_n)
      bvalid |-> bresp == RESP_OKAY) else report_mismatch("bresp", RESP_OKAY, bresp);
   a_rid: assert property (@(posedge clk) disable iff (!sync_rst_n)
      rvalid |-> rid == exp_rid) else report_mismatch("rid", exp_rid, rid);
   a_rresp: assert property (@(posedge clk) disable iff (!sync_rst_n)
      rvalid |-> rresp == RESP_OKAY) else report_mismatch("rresp", RESP_OKAY, rresp);
   a_rlast: assert property (@(posedge clk) disable iff (!sync_rst_n)
      rvalid |-> rlast) else report_mismatch("rlast", 1, rlast);
   a_rdata: assert property (@(posedge clk) disable iff (!sync_rst_n)
      rvalid |-> rdata.flat == exp_rdata) else report_mismatch("rdata", exp_rdata, rdata);

   // Back-pressure keeps the response steady
   a_b_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      b_stall_q |-> bvalid) else report_mismatch("bvalid held", 1, bvalid);
   a_bid_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      b_stall_q |-> bid == bid_q) else report_mismatch("bid held", bid_q, bid);
   a_r_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      r_stall_q |-> rvalid) else report_mismatch("rvalid held", 1, rvalid);
   a_rid_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      r_stall_q |-> rid == rid_q) else report_mismatch("rid held", rid_q, rid);
   a_rdata_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      r_stall_q |-> rdata.flat == rdata_q) else report_mismatch("rdata held", rdata_q, rdata);

   // Write wins, so no read answer while a write is open
   a_write_first: assert property (@(posedge clk) disable iff (!sync_rst_n)
      rvalid |-> !wr_outstanding) else report_error("rvalid came before the pending write");
   a_b_expected: assert property (@(posedge clk) disable iff (!sync_rst_n)
      bvalid |-> wr_outstanding) else report_error("bvalid without an open write");

   //----------------------------
   // Model helpers
   //----------------------------
   function automatic logic [CFG_DATA_W-1:0] byte_swap(input logic [CFG_DATA_W-1:0] v);
      return {v[7:0], v[15:8], v[23:16], v[31:24]};
   endfunction

   function automatic logic [AXI_DATA_W-1:0] expected_beat(input logic [AXI_ADDR_W-1:0] addr);
      logic [CFG_DATA_W-1:0] word;
      word = (addr[7:0] == HELLO_WORLD_OFS) ? byte_swap(model_reg) : UNMAPPED_RDATA;
      return {480'b0, word} << (LANE_W * int'(addr[LANE_SEL_MSB:LANE_SEL_LSB]));
   endfunction

   // Random filler in every lane but the addressed one
   function automatic logic [AXI_DATA_W-1:0] fill_beat(input logic [AXI_ADDR_W-1:0] addr,
                                                        input logic [CFG_DATA_W-1:0] value);
      logic [AXI_DATA_W-1:0] beat;
      int                    sel;
      sel = int'(addr[LANE_SEL_MSB:LANE_SEL_LSB]);
      for (int i = 0; i < NUM_LANES; i++)
         beat[i*LANE_W +: LANE_W] = (i == sel) ? value : $urandom;
      return beat;
   endfunction

   function automatic logic [AXI_ADDR_W-1:0] reg_addr();
      logic [AXI_ADDR_W-1:0] a;
      a = {$urandom, $urandom};
      a[7:0] = 8'h00;
      return a;
   endfunction

   function automatic logic [AXI_ADDR_W-1:0] unmapped_addr();
      logic [AXI_ADDR_W-1:0] a;
      a = {$urandom, $urandom};
      a[7:0] = 8'($urandom % 255) + 8'd1;
      return a;
   endfunction

   //----------------------------
   // AXI manager
   //----------------------------
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Waits for the response, then stalls it a random number of cycles
   task automatic take_response(input bit is_wr);
      int hold;
      hold = $urandom % 5;
      #1;
      while (!(is_wr ? bvalid : rvalid))
      begin
         @(posedge clk);
         #1;
      end
      next_cycle();
      repeat (hold) next_cycle();
      if (is_wr)
         bready = 1'b1;
      else
         rready = 1'b1;
      next_cycle();
      bready = 1'b0;
      rready = 1'b0;
      if (is_wr)
         wr_outstanding = 1'b0;
   endtask

   task automatic run_access(input bit do_wr, input bit do_rd,
                             input logic [AXI_ADDR_W-1:0] wr_addr,
                             input logic [CFG_DATA_W-1:0] value,
                             input logic [AXI_ADDR_W-1:0] rd_addr);
      logic aw_pend;
      logic w_pend;
      logic ar_pend;
      logic aw_hs;
      logic w_hs;
      logic ar_hs;
      if (do_wr)
      begin
         exp_bid        = AXI_ID_W'($urandom);
         awid           = exp_bid;
         awaddr         = wr_addr;
         wdata.flat     = fill_beat(wr_addr, value);
         awvalid        = 1'b1;
         wvalid         = 1'b1;
         wr_outstanding = 1'b1;
         if (wr_addr[7:0] == HELLO_WORLD_OFS)
            model_reg = value;
      end
      if (do_rd)
      begin
         exp_rid   = AXI_ID_W'($urandom);
         arid      = exp_rid;
         araddr    = rd_addr;
         arvalid   = 1'b1;
         exp_rdata = expected_beat(rd_addr);
      end
      aw_pend = do_wr;
      w_pend  = do_wr;
      ar_pend = do_rd;
      while (aw_pend || w_pend || ar_pend)
      begin
         #1;
         aw_hs = awvalid && awready;
         w_hs  = wvalid && wready;
         ar_hs = arvalid && arready;
         next_cycle();
         if (aw_hs)
         begin
            awvalid = 1'b0;
            aw_pend = 1'b0;
         end
         if (w_hs)
         begin
            wvalid = 1'b0;
            w_pend = 1'b0;
         end
         if (ar_hs)
         begin
            arvalid = 1'b0;
            ar_pend = 1'b0;
         end
      end
      if (do_wr)
         take_response(1'b1);
      if (do_rd)
         take_response(1'b0);
   endtask

   //----------------------------
   // Test sequence
   //----------------------------
   initial
   begin
      void'($urandom(32'h80f8));
      awid       = '0;
      awaddr     = '0;
      awvalid    = 1'b0;
      wdata.flat = '0;
      wvalid     = 1'b0;
      bready     = 1'b0;
      arid       = '0;
      araddr     = '0;
      arvalid    = 1'b0;
      rready     = 1'b0;
      while (sync_rst_n !== 1'b1)
         @(posedge clk);
      next_cycle();

      test_name = "reset_value";
      run_access(1'b0, 1'b1, '0, '0, reg_addr());

      test_name = "write_read";
      repeat (20)
      begin
         run_access(1'b1, 1'b0, reg_addr(), $urandom, '0);
         run_access(1'b0, 1'b1, '0, '0, reg_addr());
      end

      test_name = "unmapped_read";
      repeat (8)
         run_access(1'b0, 1'b1, '0, '0, unmapped_addr());

      test_name = "unmapped_write";
      repeat (4)
      begin
         run_access(1'b1, 1'b0, unmapped_addr(), $urandom, '0);
         run_access(1'b0, 1'b1, '0, '0, reg_addr());
      end

      // AW, W and AR in the same cycle
      test_name = "write_read_race";
      repeat (3)
         run_access(1'b1, 1'b1, reg_addr(), $urandom, reg_addr());

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
//----------------------------
// Testbench clock and reset
// 4 ns clock, reset low for the first 2 rising edges
// Reset releases 1 ns after an edge, like all stimulus
//----------------------------
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic sync_rst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      sync_rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1 sync_rst_n = 1'b1;
   end

endmodule

`default_nettype wire
